// File: design/oppm_pkg.sv
package oppm_pkg;

  // Link defaults, the top level may override the timing ones
  localparam int N_MOD       = 2;  // Bits carried per symbol
  localparam int N_PKT       = 8;  // Bits per packet
  localparam int SLOT_TICKS  = 8;  // Clock cycles per slot
  localparam int PULSE_TICKS = 2;
  localparam int PRE_SYMS    = 2;  // Preamble symbols, all in slot 0
  localparam int DELTA       = 1;  // Capture window half width in ticks

  // Tick counter width, limits SLOT_TICKS to 15
  localparam int TICK_W = 4;

  // Symbols needed to carry a number of bits, rounded up
  function automatic int sym_count(input int bits, input int bits_per_sym);
    return (bits + bits_per_sym - 1) / bits_per_sym;
  endfunction

  localparam int DATA_SYMS = sym_count(N_PKT, N_MOD);

  typedef logic [N_PKT-1:0]  pkt_t;   // Whole packet
  typedef logic [N_MOD-1:0]  sym_t;   // Slot index of one symbol
  typedef logic [TICK_W-1:0] tick_t;  // Position inside a slot

  // Receive result handed to the consumer
  typedef struct packed {
    pkt_t data;
    logic error;  // Framing failure, data forced to zero
  } rx_status_t;

endpackage

// File: design/slot_timer.sv
`timescale 1ns/1ps

module slot_timer #(
  parameter int SLOT_TICKS = oppm_pkg::SLOT_TICKS,
  parameter int DELTA      = oppm_pkg::DELTA
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start,      // Counting begins in this same cycle
  input  logic            clear,      // Stops and zeroes both counters
  output logic            run,
  output oppm_pkg::tick_t tick,
  output oppm_pkg::sym_t  slot,
  output logic            last_tick,
  output logic            last_slot,
  output logic            near_edge,  // Within DELTA ticks of a slot start
  output oppm_pkg::sym_t  near_slot   // Slot whose start is closest
);
  import oppm_pkg::*;

  localparam tick_t LAST_TICK = tick_t'(SLOT_TICKS - 1);
  localparam tick_t EARLY_MAX = tick_t'(DELTA);
  localparam tick_t LATE_MIN  = tick_t'(SLOT_TICKS - DELTA);
  localparam sym_t  LAST_SLOT = '1;

  logic run_q;
  logic at_start;
  logic at_end;

  // Window must not overlap itself and the slot must fit in tick_t
  initial begin
    assert (DELTA < SLOT_TICKS / 2 && SLOT_TICKS < 16)
      else $fatal(1, "%m: SLOT_TICKS %0d with DELTA %0d not supported", SLOT_TICKS, DELTA);
  end

  // Run latch, start only needs one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_q <= 1'b0;
    end else begin
      run_q <= run & ~clear;
    end
  end

  assign run = run_q | start;

  assign last_tick = (tick == LAST_TICK);
  assign last_slot = (slot == LAST_SLOT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tick <= '0;
      slot <= '0;
    end else if (!run || clear) begin
      tick <= '0;
      slot <= '0;
    end else if (last_tick) begin
      tick <= '0;
      slot <= slot + 1'b1;  // Wraps at the symbol end
    end else begin
      tick <= tick + 1'b1;
    end
  end

  // Near-boundary window
  assign at_start  = (tick <= EARLY_MAX);
  assign at_end    = (tick >= LATE_MIN);
  assign near_edge = at_start | at_end;

  // A late tick belongs to the slot about to begin
  assign near_slot = at_end ? slot + 1'b1 : slot;

  // Owner FSM never restarts the timer while it is clearing it
  a_start_clear_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(start && clear))
    else $error("%m: start and clear high together");

endmodule

// File: design/oppm_encoder.sv
`timescale 1ns/1ps

module oppm_encoder #(
  parameter int SLOT_TICKS  = oppm_pkg::SLOT_TICKS,
  parameter int PULSE_TICKS = oppm_pkg::PULSE_TICKS,
  parameter int PRE_SYMS    = oppm_pkg::PRE_SYMS
) (
  input  logic           clk,
  input  logic           rst_n,
  input  oppm_pkg::pkt_t tx_pkt,
  input  logic           tx_valid,
  output logic           tx_ready,
  output logic           line_out   // Optical pulse
);
  import oppm_pkg::*;

  localparam int SH_W = DATA_SYMS * N_MOD;  // Packet padded to whole symbols
  localparam int PC_W = $clog2(PRE_SYMS + 1);
  localparam int DC_W = $clog2(DATA_SYMS + 1);
  localparam int PW_W = $clog2(PULSE_TICKS + 1);

  localparam logic [PC_W-1:0] PRE_LAST  = PC_W'(PRE_SYMS);
  localparam logic [DC_W-1:0] DATA_LAST = DC_W'(DATA_SYMS - 1);
  localparam logic [PW_W-1:0] PW_LOAD   = PW_W'(PULSE_TICKS - 1);

  typedef enum logic [1:0] {IDLE, PREAM, DATA} enc_state_t;

  enc_state_t      state;
  logic [PC_W-1:0] pre_cnt;   // 0 while waiting for the first boundary
  logic [DC_W-1:0] data_cnt;
  logic [SH_W-1:0] shreg;
  logic [PW_W-1:0] pw_cnt;    // Remaining high cycles after the first

  tick_t tick;
  sym_t  slot;
  sym_t  cur_sym;
  logic  last_tick;
  logic  last_slot;
  logic  sym_end;
  logic  accept;
  logic  sending;
  logic  pulse_go;

  // Free running from reset
  slot_timer #(
    .SLOT_TICKS(SLOT_TICKS),
    .DELTA     (0)
  ) timer0 (
    .clk,
    .rst_n,
    .start    (1'b1),
    .clear    (1'b0),
    .run      (),
    .tick,
    .slot,
    .last_tick,
    .last_slot,
    .near_edge(),
    .near_slot()
  );

  assign sym_end  = last_tick & last_slot;
  assign tx_ready = (state == IDLE);
  assign accept   = tx_valid & tx_ready;

  assign sending  = (state == DATA) || (state == PREAM && pre_cnt != '0);
  assign cur_sym  = (state == DATA) ? shreg[SH_W-1 -: N_MOD] : '0;  // Preamble uses slot 0
  assign pulse_go = sending && (tick == '0) && (slot == cur_sym);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      pre_cnt  <= '0;
      data_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            state   <= PREAM;
            pre_cnt <= sym_end ? PC_W'(1) : '0;  // Boundary right now
          end
        end
        PREAM: begin
          if (sym_end) begin
            if (pre_cnt == PRE_LAST) begin
              state    <= DATA;
              data_cnt <= '0;
            end else begin
              pre_cnt <= pre_cnt + 1'b1;
            end
          end
        end
        DATA: begin
          if (sym_end) begin
            data_cnt <= data_cnt + 1'b1;
            if (data_cnt == DATA_LAST) begin
              state <= IDLE;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Shift-out register sends the MSB first
  always_ff @(posedge clk) begin
    if (accept) begin
      shreg <= SH_W'(tx_pkt) << (SH_W - N_PKT);
    end else if (state == DATA && sym_end) begin
      shreg <= shreg << N_MOD;
    end
  end

  // Pulse shaping
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      line_out <= 1'b0;
      pw_cnt   <= '0;
    end else if (pulse_go) begin
      line_out <= 1'b1;
      pw_cnt   <= PW_LOAD;
    end else if (pw_cnt != '0) begin
      pw_cnt <= pw_cnt - 1'b1;
    end else begin
      line_out <= 1'b0;
    end
  end

  // Idle with no pulse draining keeps the line dark
  a_dark_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (state == IDLE && !$past(line_out)) |-> !line_out)
    else $error("%m: line_out high while idle");

endmodule

// File: design/oppm_decoder.sv
`timescale 1ns/1ps

module oppm_decoder #(
  parameter int SLOT_TICKS = oppm_pkg::SLOT_TICKS,
  parameter int PRE_SYMS   = oppm_pkg::PRE_SYMS,
  parameter int DELTA      = oppm_pkg::DELTA
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 line_in,    // Pulse line from the receiver
  input  logic                 rx_ready,
  output oppm_pkg::rx_status_t rx_status,
  output logic                 rx_valid
);
  import oppm_pkg::*;

  localparam int SH_W = DATA_SYMS * N_MOD;
  localparam int PC_W = $clog2(PRE_SYMS + 1);
  localparam int DC_W = $clog2(DATA_SYMS + 1);

  localparam logic [PC_W-1:0] PRE_LAST  = PC_W'(PRE_SYMS);
  localparam logic [DC_W-1:0] DATA_LAST = DC_W'(DATA_SYMS - 1);

  typedef enum logic [1:0] {WAIT, PREAM, DATA, ERR} dec_state_t;

  dec_state_t      state;
  logic [PC_W-1:0] pre_cnt;     // Preamble pulses seen so far
  logic [DC_W-1:0] data_cnt;    // Data symbols taken so far
  logic [SH_W-1:0] shreg;
  logic [SH_W-1:0] shreg_next;

  logic line_q;
  logic line_qq;
  logic is_edge;
  logic first_edge;
  logic timer_start;
  logic timer_clear;
  logic near_edge;
  sym_t near_slot;
  logic pre_ok;
  logic take_sym;
  logic sym_done;
  logic bad_edge;

  slot_timer #(
    .SLOT_TICKS(SLOT_TICKS),
    .DELTA     (DELTA)
  ) timer0 (
    .clk,
    .rst_n,
    .start    (timer_start),
    .clear    (timer_clear),
    .run      (),
    .tick     (),
    .slot     (),
    .last_tick(),
    .last_slot(),
    .near_edge,
    .near_slot
  );

  // Registered rising edge detect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      line_q  <= 1'b0;
      line_qq <= 1'b0;
    end else begin
      line_q  <= line_in;
      line_qq <= line_q;
    end
  end

  assign is_edge    = line_q & ~line_qq;
  assign first_edge = is_edge && (state == WAIT);

  // Edge classification
  assign pre_ok   = is_edge && near_edge && (state == PREAM) &&
                    (pre_cnt != PRE_LAST) && (near_slot == '0);
  assign take_sym = is_edge && near_edge &&
                    ((state == DATA) || (state == PREAM && pre_cnt == PRE_LAST));
  assign sym_done = take_sym && (data_cnt == DATA_LAST);
  assign bad_edge = is_edge && (state == PREAM || state == DATA) && !pre_ok && !take_sym;

  assign shreg_next = {shreg[SH_W-N_MOD-1:0], near_slot};

  // First edge is tick 0 of slot 0
  assign timer_start = first_edge;
  assign timer_clear = (state == WAIT && !is_edge) || (state == ERR) || sym_done || bad_edge;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= WAIT;
      pre_cnt  <= '0;
      data_cnt <= '0;
    end else begin
      case (state)
        WAIT: begin
          data_cnt <= '0;
          if (is_edge) begin
            state   <= PREAM;
            pre_cnt <= PC_W'(1);  // Counts as preamble 1
          end else begin
            pre_cnt <= '0;
          end
        end
        PREAM: begin
          if (take_sym) begin
            state    <= sym_done ? WAIT : DATA;
            data_cnt <= data_cnt + 1'b1;
          end else if (pre_ok) begin
            pre_cnt <= pre_cnt + 1'b1;
          end else if (bad_edge) begin
            state <= ERR;
          end
        end
        DATA: begin
          if (sym_done) begin
            state <= WAIT;
          end else if (take_sym) begin
            data_cnt <= data_cnt + 1'b1;
          end else if (bad_edge) begin
            state <= ERR;
          end
        end
        ERR: begin
          state    <= WAIT;
          pre_cnt  <= '0;
          data_cnt <= '0;
        end
      endcase
    end
  end

  // Shift-in register
  always_ff @(posedge clk) begin
    if (take_sym) begin
      shreg <= shreg_next;
    end
  end

  // Result handshake, a new first edge drops an unread result
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_valid <= 1'b0;
    end else if (sym_done || state == ERR) begin
      rx_valid <= 1'b1;
    end else if (rx_ready || first_edge) begin
      rx_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (sym_done) begin
      rx_status.data  <= shreg_next[SH_W-1 -: N_PKT];
      rx_status.error <= 1'b0;
    end else if (state == ERR) begin
      rx_status.data  <= '0;
      rx_status.error <= 1'b1;
    end
  end

  // Pending result holds until taken or overwritten by a new packet
  a_hold_result: assert property (@(posedge clk) disable iff (!rst_n)
    (rx_valid && !rx_ready && !first_edge) |=> (rx_valid && $stable(rx_status)))
    else $error("%m: rx_status changed while waiting for rx_ready");

endmodule

// File: design/oppm_link.sv
`timescale 1ns/1ps

module oppm_link #(
  parameter int SLOT_TICKS  = oppm_pkg::SLOT_TICKS,   // Cycles per slot
  parameter int PULSE_TICKS = oppm_pkg::PULSE_TICKS,  // Pulse width in cycles
  parameter int PRE_SYMS    = oppm_pkg::PRE_SYMS,
  parameter int DELTA       = oppm_pkg::DELTA         // Receive window half width
) (
  input  logic                 clk,
  input  logic                 rst_n,

  // Transmit side
  input  oppm_pkg::pkt_t       tx_pkt,
  input  logic                 tx_valid,
  output logic                 tx_ready,
  output logic                 line_out,

  // Receive side
  input  logic                 line_in,
  output oppm_pkg::rx_status_t rx_status,
  output logic                 rx_valid,
  input  logic                 rx_ready
);

  // Transmit path, owns its own free running slot timer
  oppm_encoder #(
    .SLOT_TICKS (SLOT_TICKS),
    .PULSE_TICKS(PULSE_TICKS),
    .PRE_SYMS   (PRE_SYMS)
  ) enc0 (
    .clk,
    .rst_n,
    .tx_pkt,
    .tx_valid,
    .tx_ready,
    .line_out
  );

  // Receive path, timer locks to the first edge of each packet
  oppm_decoder #(
    .SLOT_TICKS(SLOT_TICKS),
    .PRE_SYMS  (PRE_SYMS),
    .DELTA     (DELTA)
  ) dec0 (
    .clk,
    .rst_n,
    .line_in,
    .rx_ready,
    .rx_status,
    .rx_valid
  );

endmodule

// File: testbench/oppm_link_tb.sv
`timescale 1ns/1ps

module oppm_link_tb;
  import oppm_pkg::*;

  localparam int DATA_SYM_CNT   = (N_PKT + N_MOD - 1) / N_MOD;
  localparam int ALL_SYMS       = PRE_SYMS + DATA_SYM_CNT;
  localparam int SYM_CYCLES     = (1 << N_MOD) * SLOT_TICKS;
  localparam int TX_CYCLES      = ALL_SYMS * SYM_CYCLES;
  localparam int TIMEOUT_CYCLES = 12 * TX_CYCLES * 2 + 400;  // Twelve packets twice over plus margin
  localparam int N_TESTS        = 6;

  logic       clk;
  logic       rst_n;
  pkt_t       tx_pkt;
  logic       tx_valid;
  logic       tx_ready;
  logic       line_out;
  logic       line_in;
  rx_status_t rx_status;
  logic       rx_valid;
  logic       rx_ready;
  logic       loopback;    // Line closed from transmitter to receiver
  logic       line_drive;  // Hand-made pulses when the loop is open

  logic [31:0] lfsr = 32'he46f493f;
  int          cycle_cnt = 0;
  int          rx_seen = 0;
  int          results_due = 0;
  int          test_errs = 0;
  int          err_total = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  string       cur_test = "startup";
  rx_status_t  exp_q[$];
  rx_status_t  exp_now;
  rx_status_t  held_status;
  logic        holding = 1'b0;
  logic        line_seen = 1'b0;
  int          rise_q[$];   // Cycle of each line_out rise
  int          width_q[$];  // High cycles of each pulse

  oppm_link #(
    .SLOT_TICKS (SLOT_TICKS),
    .PULSE_TICKS(PULSE_TICKS),
    .PRE_SYMS   (PRE_SYMS),
    .DELTA      (DELTA)
  ) dut0 (
    .clk, .rst_n, .tx_pkt, .tx_valid, .tx_ready, .line_out,
    .line_in, .rx_status, .rx_valid, .rx_ready
  );

  assign line_in = loopback ? line_out : line_drive;

  always #50 clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  // Symbol 0 sits in the top bits with preamble then data MSB first
  function automatic logic [ALL_SYMS*N_MOD-1:0] expected_slots(input pkt_t pkt);
    logic [ALL_SYMS*N_MOD-1:0] slots;
    int bit_idx;
    slots = '0;  // Preamble stays in slot 0 and a short last symbol is padded
    for (int k = 0; k < DATA_SYM_CNT; k++) begin
      for (int b = 0; b < N_MOD; b++) begin
        bit_idx = N_PKT - 1 - (k * N_MOD + b);
        if (bit_idx >= 0) begin
          slots[(DATA_SYM_CNT - 1 - k) * N_MOD + (N_MOD - 1 - b)] = pkt[bit_idx];
        end
      end
    end
    return slots;
  endfunction

  function automatic rx_status_t expected_rx(input pkt_t pkt, input logic err);
    rx_status_t st;
    st.data  = err ? '0 : pkt;
    st.error = err;
    return st;
  endfunction

  task automatic count_error();
    test_errs++;
    err_total++;
  endtask

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("MISMATCH %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
      count_error();
    end
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs == 0) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", cur_test, test_errs);
    end
  endtask

  task automatic expect_result(input rx_status_t st);
    exp_q.push_back(st);
    results_due++;
  endtask

  task automatic await_results();
    wait (rx_seen >= results_due);
  endtask

  task automatic send_packet(input pkt_t pkt);
    @(negedge clk);
    tx_pkt   = pkt;
    tx_valid = 1'b1;
    while (!tx_ready) @(negedge clk);
    @(negedge clk);  // Transfer happened on the edge before
    tx_valid = 1'b0;
  endtask

  // Two pulses with rise to rise distance gap
  task automatic drive_pulse_pair(input int gap);
    @(negedge clk);
    line_drive = 1'b1;
    repeat (PULSE_TICKS) @(negedge clk);
    line_drive = 1'b0;
    repeat (gap - PULSE_TICKS) @(negedge clk);
    line_drive = 1'b1;
    repeat (PULSE_TICKS) @(negedge clk);
    line_drive = 1'b0;
  endtask

  // Result checker that also watches held results under back-pressure
  always @(posedge clk) begin
    if (rst_n) begin
      if (holding) begin
        assert (rx_valid) else begin
          $display("%s: rx_valid dropped before rx_ready was given", cur_test);
          count_error();
        end
        compare("held rx_status", 32'(held_status), 32'(rx_status));
      end
      if (rx_valid && rx_ready) begin
        if (exp_q.size() == 0) begin
          $display("%s: result delivered with no packet outstanding", cur_test);
          count_error();
        end else begin
          exp_now = exp_q.pop_front();
          compare("rx_status", 32'(exp_now), 32'(rx_status));
        end
        rx_seen++;
      end
      holding     = rx_valid && !rx_ready;
      held_status = rx_status;
    end
  end

  // Pulse monitor on the transmit line
  always @(posedge clk) begin
    if (line_out && !line_seen) begin
      rise_q.push_back(cycle_cnt);
    end
    if (!line_out && line_seen && rise_q.size() != 0) begin
      width_q.push_back(cycle_cnt - rise_q[$]);
    end
    line_seen <= line_out;
  end

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("run stopped after %0d cycles without finishing test %s", cycle_cnt, cur_test);
    $display("tests failed");
    $finish;
  end

  task automatic check_reset_state();
    begin_test("reset_state");
    compare("tx_ready", 32'd1, 32'(tx_ready));
    compare("rx_valid", 32'd0, 32'(rx_valid));
    compare("line_out", 32'd0, 32'(line_out));
    end_test();
  endtask

  task automatic measure_pulse_shape();
    logic [ALL_SYMS*N_MOD-1:0] slots;
    sym_t sym;
    begin_test("pulse_shape");
    slots = expected_slots(8'hB4);
    rise_q.delete();
    width_q.delete();
    expect_result(expected_rx(8'hB4, 1'b0));
    send_packet(8'hB4);
    await_results();
    repeat (4) @(negedge clk);  // Let the last pulse fall
    assert (rise_q.size() == ALL_SYMS && width_q.size() == ALL_SYMS) else begin
      $display("%s: saw %0d pulses, %0d complete, instead of %0d",
               cur_test, rise_q.size(), width_q.size(), ALL_SYMS);
      count_error();
    end
    for (int k = 0; k < ALL_SYMS && k < width_q.size(); k++) begin
      sym = slots[(ALL_SYMS - 1 - k) * N_MOD +: N_MOD];
      if (k > 0) begin  // First rise is the reference point
        compare($sformatf("rise offset %0d", k),
                32'(k * SYM_CYCLES + int'(sym) * SLOT_TICKS), 32'(rise_q[k] - rise_q[0]));
      end
      compare($sformatf("pulse width %0d", k), 32'(PULSE_TICKS), 32'(width_q[k]));
    end
    end_test();
  endtask

  task automatic loopback_single();
    begin_test("single_loopback");
    expect_result(expected_rx(8'hB4, 1'b0));
    send_packet(8'hB4);
    await_results();
    end_test();
  endtask

  task automatic loopback_random();
    pkt_t pkt;
    int   stall;
    begin_test("random_backpressure");
    for (int n = 0; n < 10; n++) begin
      pkt   = pkt_t'(random_bits(N_PKT));
      stall = (random_bits(1) == 32'd1) ? int'(random_bits(3)) + 1 : 0;
      @(negedge clk);
      rx_ready = (stall == 0);
      expect_result(expected_rx(pkt, 1'b0));
      send_packet(pkt);
      if (stall != 0) begin
        while (!rx_valid) @(negedge clk);
        repeat (stall) @(negedge clk);  // Result must hold meanwhile
        rx_ready = 1'b1;
      end
      await_results();
    end
    end_test();
  endtask

  task automatic bad_preamble_slot();
    begin_test("bad_preamble_slot");
    @(negedge clk);
    loopback = 1'b0;
    expect_result(expected_rx('0, 1'b1));
    drive_pulse_pair(SYM_CYCLES + SLOT_TICKS);  // Slot 1 of the next symbol
    await_results();
    end_test();
  endtask

  task automatic pulse_outside_window();
    begin_test("outside_window");
    @(negedge clk);
    loopback = 1'b0;
    expect_result(expected_rx('0, 1'b1));
    drive_pulse_pair(SYM_CYCLES + SLOT_TICKS / 2);  // Mid slot at tick 4
    await_results();
    @(negedge clk);
    loopback = 1'b1;
    expect_result(expected_rx(8'h5A, 1'b0));
    send_packet(8'h5A);
    await_results();
    end_test();
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    tx_pkt     = '0;
    tx_valid   = 1'b0;
    rx_ready   = 1'b1;
    loopback   = 1'b1;
    line_drive = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    check_reset_state();
    measure_pulse_shape();
    loopback_single();
    loopback_random();
    bad_preamble_slot();
    pulse_outside_window();
    repeat (4) @(negedge clk);

    $display("%0d of %0d tests run, %0d failed, %0d errors in total",
             tests_run, N_TESTS, tests_failed, err_total);
    if (tests_failed == 0 && err_total == 0 && tests_run == N_TESTS) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: flist.f
design/oppm_pkg.sv
design/slot_timer.sv
design/oppm_encoder.sv
design/oppm_decoder.sv
design/oppm_link.sv
testbench/oppm_link_tb.sv

// File: run.sh
#!/bin/sh
# Build the OPPM link testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module oppm_link_tb -f flist.f -o oppm_link_sim \
  && ./obj_dir/oppm_link_sim > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null \
  ; grep -q "^all tests passed$" sim.log \
  || { echo "simulation failed"; exit 1; }
echo "simulation passed"
